// ==== stepper_defines.svh ====
// Constants shared by the stepper core package and RTL, pulled in with `include
`ifndef STEPPER_DEFINES_SVH
`define STEPPER_DEFINES_SVH

// Core geometry
`define STEPPER_NUM_AXES      3
`define STEPPER_WORD_BITS     64
`define STEPPER_DDA_BITS      64
`define STEPPER_DURATION_BITS 32
`define STEPPER_POS_BITS      32

// Command headers, top byte of the first word
`define STEPPER_CMD_STEP        8'h01
`define STEPPER_CMD_ENABLE      8'h0a
`define STEPPER_CMD_BRAKE       8'h0b
`define STEPPER_CMD_CLK_DIVISOR 8'h20
`define STEPPER_CMD_FAULT       8'h50
`define STEPPER_CMD_VERSION     8'hfe

`define STEPPER_DEFAULT_DIVISOR 8'd32 // Clocks per DDA tick out of reset

// Devel, major, minor, patch
`define STEPPER_VERSION 32'h00_01_00_03

`endif

// ==== stepper_pkg.sv ====
// Types shared by the stepper core RTL and testbench, imported where a module needs them
`default_nettype none
`include "stepper_defines.svh"

package stepper_pkg;

  typedef logic [`STEPPER_NUM_AXES-1:0] axis_mask_t;     // One bit per axis
  typedef logic [`STEPPER_DDA_BITS-1:0] dda_word_t;
  typedef logic signed [`STEPPER_POS_BITS-1:0] position_t;

  // DDA rate and its change per tick
  typedef struct packed {
    dda_word_t increment;
    dda_word_t increment_increment;
  } axis_params_t;

  // One coordinated move as held in a buffer slot
  typedef struct packed {
    axis_mask_t                                dir;      // 1 counts up
    logic [`STEPPER_DURATION_BITS-1:0]         duration; // In DDA ticks
    axis_params_t [`STEPPER_NUM_AXES-1:0]      axes;
  } move_t;

  // Broadcast from the sequencer to every axis
  typedef struct packed {
    logic load; // Start of a move
    logic run;  // Move in progress
  } axis_ctrl_t;

endpackage

`default_nettype wire

// ==== spi_command_decoder.sv ====
// Host word decoder: control registers, reply words and move assembly for the stepper core
`timescale 1ns/1ps
`default_nettype none
`include "stepper_defines.svh"

module spi_command_decoder (
  input  logic                                           CLK,
  input  logic                                           resetn,
  input  logic                                           word_received,
  input  logic [`STEPPER_WORD_BITS-1:0]                  word_data_received,
  input  stepper_pkg::axis_mask_t                        stepper_faultn,
  input  logic [`STEPPER_NUM_AXES*`STEPPER_POS_BITS-1:0] positions,
  output logic [`STEPPER_WORD_BITS-1:0]                  word_send_data,
  output stepper_pkg::axis_mask_t                        enable,
  output stepper_pkg::axis_mask_t                        brake,
  output logic [7:0]                                     divisor,
  output logic                                           move_write,
  output stepper_pkg::move_t                             move
);
  import stepper_pkg::*;

  // Header, duration, then increment and increment_increment per axis
  localparam int move_words = 2 + 2 * `STEPPER_NUM_AXES;
  localparam int count_bits = $clog2(move_words);

  logic                                  word_received_q; // Edge register
  logic                                  word_take;       // One pulse per host word
  logic [7:0]                            header;
  logic [7:0]                            pending_header;
  logic [count_bits-1:0]                 word_count;
  logic                                  in_move;
  position_t [`STEPPER_NUM_AXES-1:0]     pos_snap;        // Positions at the move header

  assign header  = word_data_received[`STEPPER_WORD_BITS-1 -: 8];
  assign in_move = (pending_header == `STEPPER_CMD_STEP);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q <= 1'b0;
      word_take       <= 1'b0;
    end else begin
      word_received_q <= word_received;
      word_take       <= word_received & ~word_received_q;
    end
  end

  // Control registers and replies
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_send_data <= '0;
      enable         <= '0;
      brake          <= '0;
      divisor        <= `STEPPER_DEFAULT_DIVISOR;
      move_write     <= 1'b0;
      pending_header <= '0;
      word_count     <= '0;
    end else begin
      move_write <= 1'b0;
      if (word_take) begin
        word_send_data <= '0; // Zero unless a command says otherwise
        if (!in_move) begin
          pending_header <= header;
          word_count     <= count_bits'(1);
          case (header)
            `STEPPER_CMD_ENABLE:      enable  <= word_data_received[`STEPPER_NUM_AXES-1:0];
            `STEPPER_CMD_BRAKE:       brake   <= word_data_received[`STEPPER_NUM_AXES-1:0];
            `STEPPER_CMD_CLK_DIVISOR: divisor <= word_data_received[7:0];
            `STEPPER_CMD_FAULT: begin
              word_send_data[`STEPPER_NUM_AXES-1:0] <= stepper_faultn;
            end
            `STEPPER_CMD_VERSION: begin
              word_send_data[31:0] <= `STEPPER_VERSION;
            end
            default: ;
          endcase
        end else begin
          word_count <= word_count + 1'b1;
          // Duration word returns axis 0, each increment_increment word the next axis
          for (int a = 0; a < `STEPPER_NUM_AXES; a++) begin
            if (word_count == count_bits'(2 * a + 1)) begin
              word_send_data[`STEPPER_POS_BITS-1:0] <= pos_snap[a];
            end
          end
          if (word_count == count_bits'(move_words - 1)) begin
            move_write     <= 1'b1; // Last word, hand the move over
            pending_header <= '0;
            word_count     <= '0;
          end
        end
      end
    end
  end

  // Move payload, filled word by word
  always_ff @(posedge CLK) begin
    if (word_take) begin
      if (!in_move) begin
        if (header == `STEPPER_CMD_STEP) begin
          move.dir <= word_data_received[`STEPPER_NUM_AXES-1:0];
          pos_snap <= positions;
        end
      end else begin
        if (word_count == count_bits'(1)) begin
          move.duration <= word_data_received[`STEPPER_DURATION_BITS-1:0];
        end
        for (int a = 0; a < `STEPPER_NUM_AXES; a++) begin
          if (word_count == count_bits'(2 * a + 2)) begin
            move.axes[a].increment <= word_data_received;
          end
          if (word_count == count_bits'(2 * a + 3)) begin
            move.axes[a].increment_increment <= word_data_received;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== move_sequencer.sv ====
// Move sequencer: DDA tick divider, two-slot move buffer and the run state machine
`timescale 1ns/1ps
`default_nettype none
`include "stepper_defines.svh"

module move_sequencer (
  input  logic                                             CLK,
  input  logic                                             resetn,
  input  logic [7:0]                                       divisor,
  input  logic                                             move_write,
  input  stepper_pkg::move_t                               move,
  output logic                                             dda_tick,
  output stepper_pkg::axis_ctrl_t                          ctrl,
  output stepper_pkg::axis_params_t [`STEPPER_NUM_AXES-1:0] params,
  output stepper_pkg::axis_mask_t                          dir,
  output logic                                             buffer_dtr,
  output logic                                             move_done
);
  import stepper_pkg::*;

  typedef enum logic {
    st_idle,
    st_run
  } state_t;

  state_t                            state;
  logic [7:0]                        div_count;
  logic [8:0]                        div_next;
  move_t                             slot [2];
  logic [1:0]                        full;
  logic                              wr_idx;
  logic                              rd_idx;
  logic                              load;
  logic [`STEPPER_DURATION_BITS-1:0] remaining; // Ticks left in the active move

  assign div_next = {1'b0, div_count} + 9'd1;

  // One tick every divisor clocks, divisor 0 behaves as 1
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_count <= '0;
      dda_tick  <= 1'b0;
    end else if (div_next >= {1'b0, divisor}) begin
      div_count <= '0;
      dda_tick  <= 1'b1;
    end else begin
      div_count <= div_next[7:0];
      dda_tick  <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (move_write) begin
      slot[wr_idx] <= move;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state     <= st_idle;
      full      <= '0;
      wr_idx    <= 1'b0;
      rd_idx    <= 1'b0;
      load      <= 1'b0;
      remaining <= '0;
      dir       <= '0;
      move_done <= 1'b0;
    end else begin
      load      <= 1'b0;
      move_done <= 1'b0;
      case (state)
        st_idle: begin
          if (dda_tick && full[rd_idx]) begin
            state     <= st_run;
            load      <= 1'b1;
            remaining <= slot[rd_idx].duration;
            dir       <= slot[rd_idx].dir; // Held until the next move so late steps count right
          end
        end
        st_run: begin
          // A tick in the load cycle is not seen by the axes
          if (dda_tick && !load) begin
            if (remaining < `STEPPER_DURATION_BITS'(2)) begin
              state          <= st_idle;
              move_done      <= 1'b1;
              full[rd_idx]   <= 1'b0;
              rd_idx         <= ~rd_idx;
            end else begin
              remaining <= remaining - 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
      if (move_write) begin
        full[wr_idx] <= 1'b1; // Wins over a free of the same slot
        wr_idx       <= ~wr_idx;
      end
    end
  end

  assign ctrl       = {load, state == st_run};
  assign params     = slot[rd_idx].axes;
  assign buffer_dtr = ~full[wr_idx];

endmodule

`default_nettype wire

// ==== dda_axis.sv ====
// Second-order DDA step generator, one instance per axis under the sequencer
`timescale 1ns/1ps
`default_nettype none
`include "stepper_defines.svh"

module dda_axis (
  input  logic                      CLK,
  input  logic                      resetn,
  input  logic                      dda_tick,
  input  stepper_pkg::axis_ctrl_t   ctrl,
  input  stepper_pkg::axis_params_t params,
  output logic                      step
);
  import stepper_pkg::*;

  dda_word_t                acc;
  dda_word_t                inc;     // Current rate
  logic [`STEPPER_DDA_BITS:0] acc_sum; // Top bit is the carry

  assign acc_sum = {1'b0, acc} + {1'b0, inc};

  always_ff @(posedge CLK) begin
    if (resetn) begin
      acc  <= '0;
      inc  <= '0;
      step <= 1'b0;
    end else begin
      step <= 1'b0;
      if (ctrl.load) begin
        acc <= '0;
        inc <= params.increment;
      end else if (ctrl.run && dda_tick) begin
        inc  <= inc + params.increment_increment;
        acc  <= acc_sum[`STEPPER_DDA_BITS-1:0];
        step <= acc_sum[`STEPPER_DDA_BITS]; // Overflow makes one step
      end
    end
  end

endmodule

`default_nettype wire

// ==== step_position.sv ====
// Signed step position counters for every axis, read back by the command decoder
`timescale 1ns/1ps
`default_nettype none
`include "stepper_defines.svh"

module step_position (
  input  logic                                           CLK,
  input  logic                                           resetn,
  input  stepper_pkg::axis_mask_t                        step,
  input  stepper_pkg::axis_mask_t                        dir,
  output logic [`STEPPER_NUM_AXES*`STEPPER_POS_BITS-1:0] positions
);
  import stepper_pkg::*;

  position_t [`STEPPER_NUM_AXES-1:0] pos;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      pos <= '0;
    end else begin
      for (int i = 0; i < `STEPPER_NUM_AXES; i++) begin
        if (step[i]) begin
          // Dir high counts up
          if (dir[i]) begin
            pos[i] <= pos[i] + position_t'(1);
          end else begin
            pos[i] <= pos[i] - position_t'(1);
          end
        end
      end
    end
  end

  assign positions = pos; // Axis 0 in the low bits

endmodule

`default_nettype wire

// ==== stepper_core.sv ====
// Top of the stepper command and motion core, the block a host bus and motor drivers attach to
`timescale 1ns/1ps
`default_nettype none
`include "stepper_defines.svh"

module stepper_core (
  input  logic                          CLK,
  input  logic                          resetn,
  input  logic                          word_received,
  input  logic [`STEPPER_WORD_BITS-1:0] word_data_received,
  input  stepper_pkg::axis_mask_t       stepper_faultn,
  output logic [`STEPPER_WORD_BITS-1:0] word_send_data,
  output logic                          buffer_dtr,
  output logic                          move_done,
  output stepper_pkg::axis_mask_t       step,
  output stepper_pkg::axis_mask_t       dir,
  output stepper_pkg::axis_mask_t       enable,
  output stepper_pkg::axis_mask_t       brake
);
  import stepper_pkg::*;

  logic [7:0]                                     divisor;
  logic                                           move_write;
  move_t                                          move;
  logic                                           dda_tick;
  axis_ctrl_t                                     ctrl;
  axis_params_t [`STEPPER_NUM_AXES-1:0]           params;
  logic [`STEPPER_NUM_AXES*`STEPPER_POS_BITS-1:0] positions;

  spi_command_decoder decoder_i (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_received      (word_received),
    .word_data_received (word_data_received),
    .stepper_faultn     (stepper_faultn),
    .positions          (positions),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .brake              (brake),
    .divisor            (divisor),
    .move_write         (move_write),
    .move               (move)
  );

  move_sequencer sequencer_i (
    .CLK        (CLK),
    .resetn     (resetn),
    .divisor    (divisor),
    .move_write (move_write),
    .move       (move),
    .dda_tick   (dda_tick),
    .ctrl       (ctrl),
    .params     (params),
    .dir        (dir),
    .buffer_dtr (buffer_dtr),
    .move_done  (move_done)
  );

  // One DDA per axis, all sharing tick and control
  for (genvar i = 0; i < `STEPPER_NUM_AXES; i++) begin : g_axis
    dda_axis axis_i (
      .CLK      (CLK),
      .resetn   (resetn),
      .dda_tick (dda_tick),
      .ctrl     (ctrl),
      .params   (params[i]),
      .step     (step[i])
    );
  end

  step_position position_i (
    .CLK       (CLK),
    .resetn    (resetn),
    .step      (step),
    .dir       (dir),
    .positions (positions)
  );

endmodule

`default_nettype wire

// ==== tb_stepper_core.sv ====
// Self-checking testbench for the stepper core, runs each line of the stim file in order
`timescale 1ns/1ps
`default_nettype none
`include "stepper_defines.svh"

module tb_stepper_core;
  import stepper_pkg::*;

  localparam int cycles_per_line = 20000;

  logic                          CLK;
  logic                          resetn;
  logic                          word_received;
  logic [`STEPPER_WORD_BITS-1:0] word_data_received;
  axis_mask_t                    stepper_faultn;
  logic [`STEPPER_WORD_BITS-1:0] word_send_data;
  logic                          buffer_dtr;
  logic                          move_done;
  axis_mask_t                    step;
  axis_mask_t                    dir;
  axis_mask_t                    enable;
  axis_mask_t                    brake;

  string                         names[$];
  string                         ops[$];
  logic [`STEPPER_WORD_BITS-1:0] values[$];
  logic [`STEPPER_WORD_BITS-1:0] expects[$];
  int                            errors;
  int                            passed;
  int                            failed;
  longint                        cycle_count;
  longint                        cycle_limit; // Zero until the stim file is loaded

  int                            move_word;   // Move words sent so far
  axis_mask_t                    move_dir;
  logic [`STEPPER_WORD_BITS-1:0] move_duration;
  logic [`STEPPER_WORD_BITS-1:0] move_inc [`STEPPER_NUM_AXES];
  logic [`STEPPER_WORD_BITS-1:0] move_inc_inc [`STEPPER_NUM_AXES];
  axis_mask_t                    exp_dirs[$];
  logic [`STEPPER_WORD_BITS-1:0] exp_steps[$];
  longint                        step_count [`STEPPER_NUM_AXES] = '{default: 0};
  longint                        step_base [`STEPPER_NUM_AXES];

  stepper_core stepper_core_i (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Run limit scales with the number of stim lines
  initial begin
    cycle_count = 0;
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
    $display("Regression failed");
    $finish;
  end

  // Step pulses are one clock wide, so each is seen at exactly one falling edge
  always @(negedge CLK) begin
    for (int a = 0; a < `STEPPER_NUM_AXES; a++) begin
      if (step[a] === 1'b1) begin
        step_count[a]++;
      end
    end
  end

  task automatic check_value(input string name, input logic [`STEPPER_WORD_BITS-1:0] expected,
                             input logic [`STEPPER_WORD_BITS-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Carries out of a zeroed 64-bit accumulator whose rate grows by inc_inc each tick
  function automatic logic [`STEPPER_WORD_BITS-1:0] carry_count(
      input logic [`STEPPER_WORD_BITS-1:0] ticks,
      input logic [`STEPPER_WORD_BITS-1:0] inc,
      input logic [`STEPPER_WORD_BITS-1:0] inc_inc);
    logic [191:0] total;
    total = 192'(ticks) * 192'(inc)
          + 192'(inc_inc) * 192'(ticks) * 192'(ticks - 1) / 192'd2;
    return total[`STEPPER_DDA_BITS +: `STEPPER_WORD_BITS];
  endfunction

  // Follows the coordinated step words to learn each move's dir and step counts
  task automatic track_move(input logic [`STEPPER_WORD_BITS-1:0] word);
    int a;
    if (move_word == 0) begin
      if (word[`STEPPER_WORD_BITS-1 -: 8] == `STEPPER_CMD_STEP) begin
        move_dir  = word[`STEPPER_NUM_AXES-1:0];
        move_word = 1;
      end
    end else begin
      a = (move_word - 2) / 2;
      if (move_word == 1) begin
        move_duration = `STEPPER_WORD_BITS'(word[`STEPPER_DURATION_BITS-1:0]);
      end else if (move_word % 2 == 0) begin
        move_inc[a] = word;
      end else begin
        move_inc_inc[a] = word;
      end
      move_word++;
      if (move_word == 2 + 2 * `STEPPER_NUM_AXES) begin
        exp_dirs.push_back(move_dir);
        for (int i = 0; i < `STEPPER_NUM_AXES; i++) begin
          exp_steps.push_back(carry_count(move_duration, move_inc[i], move_inc_inc[i]));
        end
        move_word = 0;
      end
    end
  endtask

  task automatic load_stim();
    int                            fd;
    int                            n;
    string                         line;
    string                         name;
    string                         op;
    logic [`STEPPER_WORD_BITS-1:0] value;
    logic [`STEPPER_WORD_BITS-1:0] expected;
    fd = $fopen("stepper_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open stepper_stim.txt for reading");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && line[0] != "#") begin // Skip comment lines
        n = $sscanf(line, "%s %s %h %h", name, op, value, expected);
        if (n == 4) begin
          names.push_back(name);
          ops.push_back(op);
          values.push_back(value);
          expects.push_back(expected);
        end else if (n > 0) begin
          $display("Malformed stim line: %s", line);
          errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Strobe held high 3 cycles and the reply read once it is low again
  task automatic send_word(input string name, input logic [`STEPPER_WORD_BITS-1:0] word,
                           input logic [`STEPPER_WORD_BITS-1:0] expected);
    word_data_received = word;
    word_received      = 1'b1;
    repeat (3) @(negedge CLK);
    word_received = 1'b0;
    check_value(name, expected, word_send_data);
    track_move(word);
    @(negedge CLK); // Low gap so the next rising edge is seen
  endtask

  // buffer_dtr must hold dtr_level until move_done, then dir and step counts match the move
  task automatic wait_move_done(input string name, input logic dtr_level);
    logic       seen;
    axis_mask_t exp_dir;
    seen = dtr_level;
    while (move_done !== 1'b1) begin
      if (buffer_dtr !== dtr_level) begin
        seen = buffer_dtr;
      end
      @(negedge CLK);
    end
    if (exp_dirs.size() == 0) begin
      $display("Move finished in test %s but no complete move was sent", name);
      errors++;
    end else begin
      exp_dir = exp_dirs.pop_front();
      check_value(name, `STEPPER_WORD_BITS'(exp_dir), `STEPPER_WORD_BITS'(dir));
    end
    @(negedge CLK); // Last step reaches the position counter
    check_value(name, `STEPPER_WORD_BITS'(dtr_level), `STEPPER_WORD_BITS'(seen));
    for (int a = 0; a < `STEPPER_NUM_AXES; a++) begin
      if (exp_steps.size() > 0) begin
        check_value(name, exp_steps.pop_front(), step_count[a] - step_base[a]);
      end
      step_base[a] = step_count[a];
    end
  endtask

  initial begin
    int err_before;
    errors             = 0;
    passed             = 0;
    failed             = 0;
    cycle_limit        = 0;
    move_word          = 0;
    resetn             = 1'b1;
    word_received      = 1'b0;
    word_data_received = '0;
    stepper_faultn     = '1; // Active low so all ones is fault free
    foreach (step_base[a]) begin
      step_base[a] = 0;
    end
    load_stim();
    if (names.size() == 0) begin
      $display("No tests found in the stim file");
      errors++;
    end
    cycle_limit = longint'(names.size()) * cycles_per_line;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    resetn = 1'b0;
    @(negedge CLK);
    foreach (names[i]) begin
      err_before = errors;
      case (ops[i])
        "send":   send_word(names[i], values[i], expects[i]);
        "done":   wait_move_done(names[i], expects[i][0]);
        "dtr":    check_value(names[i], expects[i], `STEPPER_WORD_BITS'(buffer_dtr));
        "enable": check_value(names[i], expects[i], `STEPPER_WORD_BITS'(enable));
        "brake":  check_value(names[i], expects[i], `STEPPER_WORD_BITS'(brake));
        "fault": begin
          stepper_faultn = values[i][`STEPPER_NUM_AXES-1:0];
          @(negedge CLK);
        end
        default: begin
          $display("Unknown operation %s in test %s", ops[i], names[i]);
          errors++;
        end
      endcase
      if (errors == err_before) begin
        passed++;
        $display("PASS %s", names[i]);
      end else begin
        failed++;
        $display("FAIL %s", names[i]);
      end
    end
    $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== stepper_stim.txt ====
# name op value expected, hex; send checks the reply, done waits for move_done with buffer_dtr
# held at expected, fault drives stepper_faultn, dtr/enable/brake compare that output
rst_dtr      dtr    0                0000000000000001
rst_enable   enable 0                0000000000000000
rst_brake    brake  0                0000000000000000
rst_version  send   fe00000000000000 0000000000010003
en_write     send   0a00000000000005 0000000000000000
en_check     enable 0                0000000000000005
brk_write    send   0b00000000000002 0000000000000000
brk_check    brake  0                0000000000000002
fault_drive  fault  6                0000000000000000
fault_read   send   5000000000000000 0000000000000006
div_4        send   2000000000000004 0000000000000000
m1_hdr       send   0100000000000001 0000000000000000
m1_dur       send   0000000000000028 0000000000000000
m1_inc0      send   4000000000000000 0000000000000000
m1_acc0      send   0000000000000000 0000000000000000
m1_inc1      send   0000000000000000 0000000000000000
m1_acc1      send   0000000000000000 0000000000000000
m1_inc2      send   0000000000000000 0000000000000000
m1_acc2      send   0000000000000000 0000000000000000
m1_done      done   0                0000000000000001
m2_hdr       send   0100000000000000 0000000000000000
m2_dur       send   0000000000000014 000000000000000a
m2_inc0      send   0000000000000000 0000000000000000
m2_acc0      send   0000000000000000 0000000000000000
m2_inc1      send   8000000000000000 0000000000000000
m2_acc1      send   0000000000000000 0000000000000000
m2_inc2      send   0000000000000000 0000000000000000
m2_acc2      send   0000000000000000 0000000000000000
m2_done      done   0                0000000000000001
div_64       send   2000000000000040 0000000000000000
m3_hdr       send   0100000000000003 0000000000000000
m3_dur       send   0000000000000064 000000000000000a
m3_inc0      send   4000000000000000 0000000000000000
m3_acc0      send   0000000000000000 00000000fffffff6
m3_inc1      send   8000000000000000 0000000000000000
m3_acc1      send   0000000000000000 0000000000000000
m3_inc2      send   0000000000000000 0000000000000000
m3_acc2      send   0000000000000000 0000000000000000
m4_hdr       send   0100000000000004 0000000000000000
m4_dur       send   0000000000000010 000000000000000a
m4_inc0      send   8000000000000000 0000000000000000
m4_acc0      send   0000000000000000 00000000fffffff6
m4_inc1      send   0000000000000000 0000000000000000
m4_acc1      send   0000000000000000 0000000000000000
m4_inc2      send   4000000000000000 0000000000000000
m4_acc2      send   0000000000000000 0000000000000000
m3_done      done   0                0000000000000000
m4_done      done   0                0000000000000001
m5_hdr       send   0100000000000000 0000000000000000
m5_dur       send   0000000000000001 000000000000001b
m5_inc0      send   0000000000000000 0000000000000000
m5_acc0      send   0000000000000000 0000000000000028
m5_inc1      send   0000000000000000 0000000000000000
m5_acc1      send   0000000000000000 0000000000000004

// ==== project.f ====
+incdir+.
stepper_pkg.sv
spi_command_decoder.sv
move_sequencer.sv
dda_axis.sv
step_position.sv
stepper_core.sv
tb_stepper_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/1ps -f project.f --top-module tb_stepper_core -Mdir obj_dir \
  && ./obj_dir/Vtb_stepper_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
! grep -q "Regression failed" sim.log
